//--- hw/cart_defines.svh
// ==============================
// Sizes, region bits and download indexes of the cartridge loader
// The ROM region is the upper half of the memory and the WRAM region the lower half
// ==============================
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

`define CART_ADDR_W   12
`define CART_DATA_W   16
`define CART_ROM_BIT  11
`define CART_GB_BIT   10
`define IOCTL_ADDR_W  25
`define IOCTL_INDEX_W 8

// Download indexes, GB also taken on index 8'h00
`define IDX_GB_CART   6'h01
`define IDX_SNES_CART 6'h04
`define IDX_CHEAT     8'hFF

// WRAM power-on pattern
`define FILL_BYTE_A   8'h66
`define FILL_BYTE_B   8'h99
`define FILL_BIT_HI   8
`define FILL_BIT_LO   2

`define CHEAT_WORDS   8

`endif

//--- hw/cart_pkg.sv
// ==============================
// Shared types of the cartridge loader
// Widths follow cart_defines.svh
// ==============================
`include "cart_defines.svh"

package cart_pkg;

	typedef logic [`CART_ADDR_W-1:0]   cart_addr_t;
	typedef logic [`CART_DATA_W-1:0]   cart_word_t;
	typedef logic [`IOCTL_ADDR_W-1:0]  ioctl_addr_t;
	typedef logic [`IOCTL_INDEX_W-1:0] ioctl_index_t;

	// Flags, address, compare, replace from top down
	typedef logic [`CHEAT_WORDS*`CART_DATA_W-1:0] cheat_code_t;

	// Kind of the current host download
	typedef enum logic [1:0] {
		LOAD_NONE,
		LOAD_GB,
		LOAD_SNES,
		LOAD_CHEAT
	} load_kind_t;

	typedef enum logic {
		CLR_IDLE,
		CLR_RUN
	} clear_state_t;

endpackage

//--- hw/mem_if.sv
// ==============================
// One memory client of the cartridge RAM
// Client holds req and fields until gnt; rdata follows the grant by a cycle
// ==============================
`timescale 1ns/1ps

interface mem_if;
	import cart_pkg::*;

	logic       req;
	logic       we;
	cart_addr_t addr;
	cart_word_t wdata;
	cart_word_t rdata;
	logic       gnt;

	modport client (
		output req, we, addr, wdata,
		input  rdata, gnt
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output rdata, gnt
	);

endinterface

//--- hw/cart_ram.sv
// ==============================
// Single-port synchronous RAM
// Registered read data, old contents returned on a write
// ==============================
`timescale 1ns/1ps
`include "cart_defines.svh"

module cart_ram #(
	parameter int ADDR_W = `CART_ADDR_W,
	parameter int DATA_W = `CART_DATA_W
) (
	input  logic              clk_sys,
	input  logic              we,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- hw/mem_arbiter.sv
// ==============================
// Fixed priority: load, then clear, then cpu
// Grant is combinational, access at the closing edge
// ==============================
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                clk_sys,
	input  logic                reset,
	mem_if.arbiter              load_bus,
	mem_if.arbiter              clear_bus,
	mem_if.arbiter              cpu_bus,
	output logic                ram_we,
	output cart_pkg::cart_addr_t ram_addr,
	output cart_pkg::cart_word_t ram_wdata,
	input  cart_pkg::cart_word_t ram_rdata,
	output logic                cpu_ack
);
	import cart_pkg::*;

	// Grants
	assign load_bus.gnt  = load_bus.req;
	assign clear_bus.gnt = clear_bus.req & ~load_bus.req;
	assign cpu_bus.gnt   = cpu_bus.req & ~load_bus.req & ~clear_bus.req;

	// RAM port mux
	always_comb begin
		ram_we    = 1'b0;
		ram_addr  = cpu_bus.addr;
		ram_wdata = cpu_bus.wdata;
		if (load_bus.req) begin
			ram_we    = load_bus.we;
			ram_addr  = load_bus.addr;
			ram_wdata = load_bus.wdata;
		end else if (clear_bus.req) begin
			ram_we    = clear_bus.we;
			ram_addr  = clear_bus.addr;
			ram_wdata = clear_bus.wdata;
		end else if (cpu_bus.req) begin
			ram_we = cpu_bus.we;
		end
	end

	// Read data is shared, each client knows when it was granted
	assign load_bus.rdata  = ram_rdata;
	assign clear_bus.rdata = ram_rdata;
	assign cpu_bus.rdata   = ram_rdata;

	// CPU ack lines up with its read data
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_ack <= 1'b0;
		end else begin
			cpu_ack <= cpu_bus.gnt;
		end
	end

endmodule

//--- hw/ioctl_router.sv
// ==============================
// Host download router
// Cart words become one-cycle memory writes, cheat words go out as strobes
// Indexes other than GB, SNES and cheat are dropped
// ==============================
`timescale 1ns/1ps
`include "cart_defines.svh"

module ioctl_router (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  cart_pkg::ioctl_index_t ioctl_index,
	input  cart_pkg::ioctl_addr_t  ioctl_addr,
	input  cart_pkg::cart_word_t   ioctl_dout,
	mem_if.client                  load_bus,
	output logic                   snes_loading,
	output logic                   cheat_wr,
	output logic [$clog2(`CHEAT_WORDS)-1:0] cheat_offset,
	output cart_pkg::cart_word_t   cheat_data
);
	import cart_pkg::*;

	load_kind_t kind;
	logic       cart_wr;
	cart_addr_t cart_addr;

	always_comb begin
		if (ioctl_index == `IDX_CHEAT)
			kind = LOAD_CHEAT;
		else if (ioctl_index[5:0] == `IDX_SNES_CART)
			kind = LOAD_SNES;
		else if (ioctl_index[5:0] == `IDX_GB_CART || ioctl_index == '0)
			kind = LOAD_GB;
		else
			kind = LOAD_NONE;
	end

	assign cart_wr = ioctl_download & ioctl_wr & (kind == LOAD_SNES || kind == LOAD_GB);

	// ROM region, bank bit from the kind, host byte address to word address
	always_comb begin
		cart_addr                       = '0;
		cart_addr[`CART_ROM_BIT]        = 1'b1;
		cart_addr[`CART_GB_BIT]         = (kind == LOAD_GB);
		cart_addr[`CART_GB_BIT-1:0]     = ioctl_addr[`CART_GB_BIT:1];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_bus.req <= 1'b0;
		end else begin
			load_bus.req <= cart_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			load_bus.addr  <= cart_addr;
			load_bus.wdata <= ioctl_dout;
		end
	end

	// Loader only ever writes
	assign load_bus.we = 1'b1;

	assign snes_loading = ioctl_download & (kind == LOAD_SNES);

	assign cheat_wr     = ioctl_download & ioctl_wr & (kind == LOAD_CHEAT);
	assign cheat_offset = ioctl_addr[$clog2(`CHEAT_WORDS):1];
	assign cheat_data   = ioctl_dout;

endmodule

//--- hw/wram_clear.sv
// ==============================
// WRAM power-on fill
// Starts on each new SNES download, one word per grant
// Run time depends on load traffic
// ==============================
`timescale 1ns/1ps
`include "cart_defines.svh"

module wram_clear (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  snes_loading,
	mem_if.client clear_bus,
	output logic  clearing
);
	import cart_pkg::*;

	clear_state_t             state;
	logic                     snes_loading_q;
	logic                     start;
	logic [`CART_ROM_BIT-1:0] fill_addr;
	logic [7:0]               fill_byte;

	assign start = snes_loading & ~snes_loading_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state          <= CLR_IDLE;
			snes_loading_q <= 1'b0;
			fill_addr      <= '0;
		end else begin
			snes_loading_q <= snes_loading;
			if (start) begin
				// A new download restarts the walk
				state     <= CLR_RUN;
				fill_addr <= '0;
			end else if (state == CLR_RUN && clear_bus.gnt) begin
				if (&fill_addr)
					state <= CLR_IDLE;
				else
					fill_addr <= fill_addr + 1'b1;
			end
		end
	end

	// Pattern from two address bits
	assign fill_byte = (fill_addr[`FILL_BIT_HI] ^ fill_addr[`FILL_BIT_LO]) ?
		`FILL_BYTE_A : `FILL_BYTE_B;

	assign clear_bus.req   = (state == CLR_RUN);
	assign clear_bus.we    = 1'b1;
	assign clear_bus.addr  = cart_addr_t'(fill_addr);
	assign clear_bus.wdata = {fill_byte, fill_byte};

	assign clearing = (state == CLR_RUN);

endmodule

//--- hw/cheat_assembler.sv
// ==============================
// Cheat code assembler
// Eight words per code, slot 7 completes it
// Code keeps its last value until overwritten
// ==============================
`timescale 1ns/1ps
`include "cart_defines.svh"

module cheat_assembler (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               cheat_wr,
	input  logic [$clog2(`CHEAT_WORDS)-1:0]    cheat_offset,
	input  cart_pkg::cart_word_t               cheat_data,
	output cart_pkg::cheat_code_t              cheat_code,
	output logic                               cheat_valid
);
	import cart_pkg::*;

	logic [$clog2(`CHEAT_WORDS)-1:0] word_idx;

	// ==============================
	// Slot to field
	// ==============================
	// Slot pairs: flags, address, compare, replace, low word first.
	// Fields sit top down in the code, so the pair index is inverted
	// and the low/high bit stays as is.
	assign word_idx = {~cheat_offset[2:1], cheat_offset[0]};

	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			cheat_code[word_idx*`CART_DATA_W +: `CART_DATA_W] <= cheat_data;
		end
	end

	// ==============================
	// Completion pulse
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= cheat_wr && (cheat_offset == ($clog2(`CHEAT_WORDS))'(`CHEAT_WORDS - 1));
		end
	end

endmodule

//--- hw/cart_loader_top.sv
// ==============================
// Cartridge loading path
// CPU holds cpu_req and fields until cpu_ack
// cpu_rdata is valid in the cpu_ack cycle
// ==============================
`timescale 1ns/1ps
`include "cart_defines.svh"

module cart_loader_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  cart_pkg::ioctl_index_t ioctl_index,
	input  cart_pkg::ioctl_addr_t  ioctl_addr,
	input  cart_pkg::cart_word_t   ioctl_dout,
	input  logic                   cpu_req,
	input  logic                   cpu_we,
	input  cart_pkg::cart_addr_t   cpu_addr,
	input  cart_pkg::cart_word_t   cpu_wdata,
	output cart_pkg::cart_word_t   cpu_rdata,
	output logic                   cpu_ack,
	output logic                   busy,
	output logic                   cheat_valid,
	output cart_pkg::cheat_code_t  cheat_code
);
	import cart_pkg::*;

	mem_if load_bus ();
	mem_if clear_bus ();
	mem_if cpu_bus ();

	logic                            snes_loading;
	logic                            clearing;
	logic                            cheat_wr;
	logic [$clog2(`CHEAT_WORDS)-1:0] cheat_offset;
	cart_word_t                      cheat_data;
	logic                            ram_we;
	cart_addr_t                      ram_addr;
	cart_word_t                      ram_wdata;
	cart_word_t                      ram_rdata;

	// CPU side
	assign cpu_bus.req   = cpu_req;
	assign cpu_bus.we    = cpu_we;
	assign cpu_bus.addr  = cpu_addr;
	assign cpu_bus.wdata = cpu_wdata;
	assign cpu_rdata     = cpu_bus.rdata;

	assign busy = ioctl_download | clearing;

	ioctl_router u_router (
		.clk_sys, .reset, .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr,
		.ioctl_dout, .load_bus(load_bus.client), .snes_loading, .cheat_wr,
		.cheat_offset, .cheat_data
	);

	wram_clear u_clear (
		.clk_sys, .reset, .snes_loading, .clear_bus(clear_bus.client), .clearing
	);

	cheat_assembler u_cheat (
		.clk_sys, .reset, .cheat_wr, .cheat_offset, .cheat_data, .cheat_code, .cheat_valid
	);

	mem_arbiter u_arb (
		.clk_sys, .reset, .load_bus(load_bus.arbiter), .clear_bus(clear_bus.arbiter),
		.cpu_bus(cpu_bus.arbiter), .ram_we, .ram_addr, .ram_wdata, .ram_rdata, .cpu_ack
	);

	cart_ram #(.ADDR_W(`CART_ADDR_W), .DATA_W(`CART_DATA_W)) u_ram (
		.clk_sys, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
	);

endmodule

//--- tests/tb_clock.sv
// ==============================
// Testbench clock and reset
// 4 ns period, reset high for 3 cycles and released on a falling edge
// ==============================
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	localparam int HALF_PERIOD_NS = 2;

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

	always #HALF_PERIOD_NS clk_sys = ~clk_sys;

endmodule

//--- tests/tb_cart_loader.sv
// ==============================
// Directed tests of the cartridge loading path
// Inputs change and outputs are sampled on falling edges
// Stops at the first error
// ==============================
`timescale 1ns/1ps
`include "cart_defines.svh"

module tb_cart_loader;
	import cart_pkg::*;

	// Whole run is near 2,300 cycles and mostly the 2048-word WRAM clear
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int ACK_WAIT_MAX   = 16;

	logic         clk_sys;
	logic         reset;
	logic         ioctl_download;
	logic         ioctl_wr;
	ioctl_index_t ioctl_index;
	ioctl_addr_t  ioctl_addr;
	cart_word_t   ioctl_dout;
	logic         cpu_req;
	logic         cpu_we;
	cart_addr_t   cpu_addr;
	cart_word_t   cpu_wdata;
	cart_word_t   cpu_rdata;
	logic         cpu_ack;
	logic         busy;
	logic         cheat_valid;
	cheat_code_t  cheat_code;

	logic [31:0]  lfsr_state;
	int           cycle_count;
	int           valid_count;
	cart_word_t   snes_words [16];
	cart_word_t   gb_words [8];
	cart_word_t   cheat_words [8];
	cart_word_t   cpu_words [8];

	tb_clock clock0 (.clk_sys, .reset);

	cart_loader_top dut0 (
		.clk_sys, .reset, .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr,
		.ioctl_dout, .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_rdata, .cpu_ack,
		.busy, .cheat_valid, .cheat_code
	);

	// ==============================
	// Checking and stimulus helpers
	// ==============================
	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string test, input logic [127:0] expected,
			input logic [127:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch in %s: expected %0h, actual %0h", test, expected, actual);
			stop_with_failure();
		end
	endtask

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cheat_valid)
			valid_count++;
		assert (cycle_count < TIMEOUT_CYCLES) else begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic next_random_word(output cart_word_t word);
		for (int i = 0; i < `CART_DATA_W; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			word[i]    = lfsr_state[0];
		end
	endtask

	// ROM region word address with the bank bit picking GB
	function automatic cart_addr_t rom_word_addr(input logic gb_bank, input int word);
		cart_addr_t addr;
		addr                = cart_addr_t'(word);
		addr[`CART_ROM_BIT] = 1'b1;
		addr[`CART_GB_BIT]  = gb_bank;
		return addr;
	endfunction

	function automatic cart_word_t fill_word(input cart_addr_t addr);
		logic [7:0] fill;
		fill = (addr[`FILL_BIT_HI] != addr[`FILL_BIT_LO]) ? `FILL_BYTE_A : `FILL_BYTE_B;
		return {fill, fill};
	endfunction

	task automatic start_download(input ioctl_index_t index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic download_word(input int byte_addr, input cart_word_t data);
		ioctl_wr   = 1'b1;
		ioctl_addr = ioctl_addr_t'(byte_addr);
		ioctl_dout = data;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic cpu_access(input logic we, input cart_addr_t addr,
			input cart_word_t wdata, output cart_word_t rdata);
		int waited;
		waited    = 0;
		cpu_req   = 1'b1;
		cpu_we    = we;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		do begin
			@(negedge clk_sys);
			waited++;
			assert (waited <= ACK_WAIT_MAX) else begin
				$display("CPU access at %0h got no cpu_ack in %0d cycles", addr, ACK_WAIT_MAX);
				stop_with_failure();
			end
		end while (!cpu_ack);
		rdata   = cpu_rdata;
		cpu_req = 1'b0;
		cpu_we  = 1'b0;
	endtask

	// ==============================
	// Tests
	// ==============================
	// Called on the falling edge that releases reset
	task automatic reset_values();
		check_value("reset_values cpu_ack", 128'(1'b0), 128'(cpu_ack));
		check_value("reset_values cheat_valid", 128'(1'b0), 128'(cheat_valid));
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		cpu_req        = 1'b0;
		@(negedge clk_sys);
		check_value("reset_values busy", 128'(1'b0), 128'(busy));
	endtask

	task automatic snes_download();
		cart_word_t rdata;
		start_download(8'h04);
		for (int i = 0; i < 16; i++) begin
			next_random_word(snes_words[i]);
			download_word(2 * i, snes_words[i]);
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_value("snes_download busy during clear", 128'(1'b1), 128'(busy));
		while (busy)
			@(negedge clk_sys);
		for (int i = 0; i < 16; i++) begin
			cpu_access(1'b0, rom_word_addr(1'b0, i), '0, rdata);
			check_value("snes_download", 128'(snes_words[i]), 128'(rdata));
		end
	endtask

	task automatic wram_fill();
		cart_addr_t samples [8];
		cart_word_t rdata;
		samples = '{12'd0, 12'd4, 12'd256, 12'd260, 12'd777, 12'd1028, 12'd1536, 12'd2047};
		foreach (samples[i]) begin
			cpu_access(1'b0, samples[i], '0, rdata);
			check_value("wram_fill", 128'(fill_word(samples[i])), 128'(rdata));
		end
	endtask

	task automatic gb_download();
		cart_word_t rdata;
		start_download(8'h01);
		for (int i = 0; i < 8; i++) begin
			next_random_word(gb_words[i]);
			download_word(2 * i, gb_words[i]);
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_value("gb_download busy", 128'(1'b0), 128'(busy));
		for (int i = 0; i < 8; i++) begin
			cpu_access(1'b0, rom_word_addr(1'b1, i), '0, rdata);
			check_value("gb_download", 128'(gb_words[i]), 128'(rdata));
		end
		for (int i = 0; i < 16; i++) begin
			cpu_access(1'b0, rom_word_addr(1'b0, i), '0, rdata);
			check_value("gb_download snes kept", 128'(snes_words[i]), 128'(rdata));
		end
	endtask

	task automatic cheat_code_load();
		cheat_code_t expected;
		valid_count = 0;
		start_download(8'hFF);
		for (int slot = 0; slot < `CHEAT_WORDS; slot++) begin
			check_value("cheat_code_load early valid", 128'(1'b0), 128'(cheat_valid));
			next_random_word(cheat_words[slot]);
			download_word(2 * slot, cheat_words[slot]);
		end
		// Flags, address, compare and replace top down with the high word over the low word
		expected = {cheat_words[1], cheat_words[0], cheat_words[3], cheat_words[2],
			cheat_words[5], cheat_words[4], cheat_words[7], cheat_words[6]};
		check_value("cheat_code_load valid", 128'(1'b1), 128'(cheat_valid));
		check_value("cheat_code_load code", expected, cheat_code);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_value("cheat_code_load valid end", 128'(1'b0), 128'(cheat_valid));
		@(negedge clk_sys);
		check_value("cheat_code_load pulses", 128'(1), 128'(valid_count));
	endtask

	task automatic cpu_write_read();
		cart_word_t rdata;
		for (int i = 0; i < 8; i++) begin
			next_random_word(cpu_words[i]);
			cpu_access(1'b1, cart_addr_t'(256 + 37 * i), cpu_words[i], rdata);
		end
		for (int i = 0; i < 8; i++) begin
			cpu_access(1'b0, cart_addr_t'(256 + 37 * i), '0, rdata);
			check_value("cpu_write_read", 128'(cpu_words[i]), 128'(rdata));
		end
	endtask

	initial begin
		lfsr_state     = 32'hab6e;
		cycle_count    = 0;
		valid_count    = 0;
		// CPU read and last cheat word pending while reset holds
		ioctl_download = 1'b1;
		ioctl_wr       = 1'b1;
		ioctl_index    = 8'hFF;
		ioctl_addr     = 25'd14;
		ioctl_dout     = '0;
		cpu_req        = 1'b1;
		cpu_we         = 1'b0;
		cpu_addr       = '0;
		cpu_wdata      = '0;
		@(negedge reset);
		reset_values();
		snes_download();
		wram_fill();
		gb_download();
		cheat_code_load();
		cpu_write_read();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- src.f
+incdir+hw
hw/cart_pkg.sv
hw/mem_if.sv
hw/cart_ram.sv
hw/mem_arbiter.sv
hw/ioctl_router.sv
hw/wram_clear.sv
hw/cheat_assembler.sv
hw/cart_loader_top.sv
tests/tb_clock.sv
tests/tb_cart_loader.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; the status follows the testbench result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f src.f --top-module tb_cart_loader \
		-o sim_cart_loader \
	&& ./obj_dir/sim_cart_loader | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "run_sim: passed" \
	|| { echo "run_sim: failed"; exit 1; }
